// File: burst_checker.sv
// Regenerates the expected counting pattern and compares it against each captured burst
module burst_checker
  import qdr_cfg_pkg::*;
(
  input  logic                  clk0,
  input  logic                  module_rst,
  input  logic                  run_start_i,
  input  burst_u                burst_i,
  input  logic                  burst_valid_i,
  output logic                  mismatch_o,
  output burst_u                bad_burst_o,
  output logic [ADDR_WIDTH-1:0] bad_addr_o,
  output logic [ADDR_WIDTH-1:0] bursts_checked_o
);

  logic [DATA_WIDTH-1:0] exp_base;
  logic [ADDR_WIDTH-1:0] chk_addr;
  logic                  differ;
  logic                  mismatch_q;

  // Word w of burst a should read 4a + w
  always_comb begin
    differ = 1'b0;
    for (int w = 0; w < BURST_WORDS; w++) begin
      if (burst_i.word[w] != exp_base + DATA_WIDTH'(w)) begin
        differ = 1'b1;
      end
    end
  end

  always_ff @(posedge clk0) begin
    if (module_rst || run_start_i) begin
      exp_base   <= '0;
      chk_addr   <= '0;
      mismatch_q <= 1'b0;
    end else begin
      mismatch_q <= burst_valid_i && differ;
      if (burst_valid_i) begin
        exp_base <= exp_base + DATA_WIDTH'(BURST_WORDS);
        chk_addr <= chk_addr + ADDR_WIDTH'(1);
      end
    end
  end

  // Captured with every burst, meaningful only alongside mismatch
  always_ff @(posedge clk0) begin
    if (burst_valid_i) begin
      bad_burst_o <= burst_i;
      bad_addr_o  <= chk_addr;
    end
  end

  assign mismatch_o       = mismatch_q;
  assign bursts_checked_o = chk_addr;

endmodule

// File: compile.f
qdr_cfg_pkg.sv
status_map_pkg.sv
test_sequencer.sv
read_capture.sv
burst_checker.sv
fault_log.sv
status_regs.sv
qdr_test_harness.sv
qdr_test_harness_assertions.sv
tb_qdr_test_harness.sv

// File: fault_log.sv
// Holds the fault flag, a saturating fault count and the first mismatching bursts
module fault_log
  import qdr_cfg_pkg::*;
(
  input  logic                       clk0,
  input  logic                       module_rst,
  input  logic                       run_start_i,
  input  logic                       mismatch_i,
  input  burst_u                     bad_burst_i,
  input  logic [ADDR_WIDTH-1:0]      bad_addr_i,
  input  logic [FAULT_IDX_WIDTH-1:0] rec_sel_i,
  output logic                       test_fault_o,
  output logic [FAULT_CNT_WIDTH-1:0] fault_cnt_o,
  output burst_u                     rec_burst_o,
  output logic [ADDR_WIDTH-1:0]      rec_addr_o
);

  logic                       fault_q;
  logic [FAULT_CNT_WIDTH-1:0] cnt_q;
  logic                       log_room;
  burst_u                     rec_burst_mem [FAULT_DEPTH];
  logic [ADDR_WIDTH-1:0]      rec_addr_mem  [FAULT_DEPTH];

  assign log_room = (cnt_q < FAULT_CNT_WIDTH'(FAULT_DEPTH));

  always_ff @(posedge clk0) begin
    if (module_rst || run_start_i) begin
      fault_q <= 1'b0;
      cnt_q   <= '0;
    end else if (mismatch_i) begin
      fault_q <= 1'b1;
      // Count stops at FAULT_DEPTH
      if (log_room) begin
        cnt_q <= cnt_q + FAULT_CNT_WIDTH'(1);
      end
    end
  end

  // Later faults leave the stored records alone
  always_ff @(posedge clk0) begin
    if (mismatch_i && log_room) begin
      rec_burst_mem[cnt_q[FAULT_IDX_WIDTH-1:0]] <= bad_burst_i;
      rec_addr_mem[cnt_q[FAULT_IDX_WIDTH-1:0]]  <= bad_addr_i;
    end
  end

  assign test_fault_o = fault_q;
  assign fault_cnt_o  = cnt_q;
  assign rec_burst_o  = rec_burst_mem[rec_sel_i];
  assign rec_addr_o   = rec_addr_mem[rec_sel_i];

endmodule

// File: qdr_cfg_pkg.sv
// Memory geometry, sequencer encodings and burst type shared by the QDR test harness RTL
package qdr_cfg_pkg;

  localparam int DATA_WIDTH      = 18;
  localparam int ADDR_WIDTH      = 22;
  localparam int BURST_WORDS     = 4;

  // Fault log holds the first FAULT_DEPTH mismatching bursts
  localparam int FAULT_DEPTH     = 4;
  localparam int FAULT_CNT_WIDTH = 3;
  localparam int FAULT_IDX_WIDTH = $clog2(FAULT_DEPTH);

  // Word slots inside one beat pair
  localparam int BEAT_LO = 0;
  localparam int BEAT_HI = 1;

  // Run sequencer states
  localparam int SEQ_STATE_WIDTH = 4;
  localparam logic [SEQ_STATE_WIDTH-1:0] SEQ_IDLE   = 4'd0;
  localparam logic [SEQ_STATE_WIDTH-1:0] SEQ_WR0    = 4'd1;
  localparam logic [SEQ_STATE_WIDTH-1:0] SEQ_WR1    = 4'd2;
  localparam logic [SEQ_STATE_WIDTH-1:0] SEQ_WR_BO  = 4'd3;
  localparam logic [SEQ_STATE_WIDTH-1:0] SEQ_TURN   = 4'd4;
  localparam logic [SEQ_STATE_WIDTH-1:0] SEQ_RD0    = 4'd5;
  localparam logic [SEQ_STATE_WIDTH-1:0] SEQ_RD1    = 4'd6;
  localparam logic [SEQ_STATE_WIDTH-1:0] SEQ_RD_BO  = 4'd7;
  localparam logic [SEQ_STATE_WIDTH-1:0] SEQ_WAIT   = 4'd8;

  // One burst, filled as two beat pairs and checked as four words.
  // pair[0][BEAT_LO] is word 0, pair[0][BEAT_HI] is word 1
  typedef union packed {
    logic [1:0][1:0][DATA_WIDTH-1:0]        pair;
    logic [BURST_WORDS-1:0][DATA_WIDTH-1:0] word;
  } burst_u;

endpackage

// File: qdr_test_harness.sv
// Top level of the QDR SRAM self-checking test harness, connecting sequencer, checker and status
module qdr_test_harness
  import qdr_cfg_pkg::*;
  import status_map_pkg::*;
(
  input  logic                         clk0,
  input  logic                         module_rst,
  input  logic                         cal_done_i,
  input  logic                         start_i,
  input  logic [ADDR_WIDTH-1:0]        mem_bursts_i,
  input  logic                         user_wr_full_i,
  input  logic                         user_rd_full_i,
  input  logic                         user_qr_valid_i,
  input  logic [DATA_WIDTH-1:0]        user_qrl_i,
  input  logic [DATA_WIDTH-1:0]        user_qrh_i,
  output logic [DATA_WIDTH-1:0]        user_dwl_o,
  output logic [DATA_WIDTH-1:0]        user_dwh_o,
  output logic [ADDR_WIDTH-1:0]        user_ad_o,
  output logic                         user_ad_w_n_o,
  output logic                         user_d_w_n_o,
  output logic                         user_r_n_o,
  input  logic [STATUS_ADDR_WIDTH-1:0] status_addr_i,
  output logic [15:0]                  status_data_o
);

  logic                       run_start;
  logic                       test_done;
  logic                       data_end;
  burst_u                     burst;
  logic                       burst_valid;
  logic                       mismatch;
  burst_u                     bad_burst;
  logic [ADDR_WIDTH-1:0]      bad_addr;
  logic [ADDR_WIDTH-1:0]      bursts_checked;
  logic                       test_fault;
  logic [FAULT_CNT_WIDTH-1:0] fault_cnt;
  burst_u                     rec_burst;
  logic [ADDR_WIDTH-1:0]      rec_addr;
  logic [FAULT_IDX_WIDTH-1:0] rec_sel;

  test_sequencer u_sequencer (
    .clk0           (clk0),
    .module_rst     (module_rst),
    .cal_done_i     (cal_done_i),
    .start_i        (start_i),
    .mem_bursts_i   (mem_bursts_i),
    .user_wr_full_i (user_wr_full_i),
    .user_rd_full_i (user_rd_full_i),
    .data_end_i     (data_end),
    .user_ad_w_n_o  (user_ad_w_n_o),
    .user_d_w_n_o   (user_d_w_n_o),
    .user_r_n_o     (user_r_n_o),
    .user_ad_o      (user_ad_o),
    .user_dwl_o     (user_dwl_o),
    .user_dwh_o     (user_dwh_o),
    .run_start_o    (run_start),
    .test_done_o    (test_done)
  );

  read_capture u_capture (
    .clk0            (clk0),
    .module_rst      (module_rst),
    .user_qr_valid_i (user_qr_valid_i),
    .user_qrl_i      (user_qrl_i),
    .user_qrh_i      (user_qrh_i),
    .burst_o         (burst),
    .burst_valid_o   (burst_valid),
    .data_end_o      (data_end)
  );

  burst_checker u_checker (
    .clk0             (clk0),
    .module_rst       (module_rst),
    .run_start_i      (run_start),
    .burst_i          (burst),
    .burst_valid_i    (burst_valid),
    .mismatch_o       (mismatch),
    .bad_burst_o      (bad_burst),
    .bad_addr_o       (bad_addr),
    .bursts_checked_o (bursts_checked)
  );

  fault_log u_fault_log (
    .clk0         (clk0),
    .module_rst   (module_rst),
    .run_start_i  (run_start),
    .mismatch_i   (mismatch),
    .bad_burst_i  (bad_burst),
    .bad_addr_i   (bad_addr),
    .rec_sel_i    (rec_sel),
    .test_fault_o (test_fault),
    .fault_cnt_o  (fault_cnt),
    .rec_burst_o  (rec_burst),
    .rec_addr_o   (rec_addr)
  );

  status_regs u_status (
    .status_addr_i    (status_addr_i),
    .test_done_i      (test_done),
    .test_fault_i     (test_fault),
    .fault_cnt_i      (fault_cnt),
    .bursts_checked_i (bursts_checked),
    .rec_burst_i      (rec_burst),
    .rec_addr_i       (rec_addr),
    .rec_sel_o        (rec_sel),
    .status_data_o    (status_data_o)
  );

endmodule

// File: qdr_test_harness_assertions.sv
// Concurrent protocol checks for the QDR test harness, bound into the top level by the testbench
module qdr_test_harness_assertions
  import qdr_cfg_pkg::*;
(
  input logic                       clk0,
  input logic                       module_rst,
  input logic [ADDR_WIDTH-1:0]      bursts_i,
  input logic                       wr_full_i,
  input logic                       rd_full_i,
  input logic                       ad_w_n_i,
  input logic                       d_w_n_i,
  input logic                       r_n_i,
  input logic [ADDR_WIDTH-1:0]      ad_i,
  input logic [DATA_WIDTH-1:0]      dwl_i,
  input logic [DATA_WIDTH-1:0]      dwh_i,
  input logic                       run_start_i,
  input logic                       data_end_i,
  input logic                       done_i,
  input logic                       fault_i,
  input logic [FAULT_CNT_WIDTH-1:0] fault_cnt_i,
  input logic [ADDR_WIDTH-1:0]      bursts_checked_i
);

  int                    fail_count = 0;
  logic [ADDR_WIDTH-1:0] wr_next;
  logic [ADDR_WIDTH-1:0] rd_next;
  logic [ADDR_WIDTH-1:0] wr_ad_q;
  logic                  rd_last_q;
  logic                  wr_prev;
  logic                  wr_hold_q;
  logic                  rd_hold_q;

  // Next expected address of each phase
  always_ff @(posedge clk0) begin
    if (module_rst || run_start_i) begin
      wr_next <= '0;
      rd_next <= '0;
    end else begin
      if (!ad_w_n_i) wr_next <= ad_i + ADDR_WIDTH'(1);
      if (!r_n_i) rd_next <= ad_i + ADDR_WIDTH'(1);
    end
  end

  // Address of the write burst whose second beat follows
  always_ff @(posedge clk0) begin
    if (!ad_w_n_i) begin
      wr_ad_q <= ad_i;
    end
  end

  // Last read strobe seen, the sequencer now waits for the end of read data
  always_ff @(posedge clk0) begin
    if (module_rst || run_start_i) begin
      rd_last_q <= 1'b0;
    end else if (!r_n_i && (ad_i == bursts_i - ADDR_WIDTH'(1))) begin
      rd_last_q <= 1'b1;
    end
  end

  // Back-off windows, from a full flag seen in WR1 or RD1 until it drops
  always_ff @(posedge clk0) begin
    if (module_rst) begin
      wr_prev   <= 1'b0;
      wr_hold_q <= 1'b0;
      rd_hold_q <= 1'b0;
    end else begin
      wr_prev   <= !ad_w_n_i;
      wr_hold_q <= (wr_prev || wr_hold_q) && wr_full_i;
      rd_hold_q <= (!r_n_i || rd_hold_q) && rd_full_i;
    end
  end

  a_reset_idle: assert property (@(posedge clk0)
    module_rst |=> ad_w_n_i && d_w_n_i && r_n_i && !done_i && !fault_i)
    else begin
      $error("** Error at %0t: strobes or flags not idle after reset", $time);
      fail_count++;
    end

  a_strobe_pair: assert property (@(posedge clk0) disable iff (module_rst)
    ad_w_n_i == d_w_n_i)
    else begin
      $error("** Error at %0t: user_d_w_n_o got %b expected %b", $time, d_w_n_i, ad_w_n_i);
      fail_count++;
    end

  a_wr_addr: assert property (@(posedge clk0) disable iff (module_rst)
    !ad_w_n_i |-> (ad_i == wr_next) && (ad_i < bursts_i))
    else begin
      $error("** Error at %0t: user_ad_o got %h expected %h", $time, ad_i, wr_next);
      fail_count++;
    end

  a_wr_beat0: assert property (@(posedge clk0) disable iff (module_rst)
    !ad_w_n_i |-> (dwl_i == DATA_WIDTH'({ad_i, 2'b00})) && (dwh_i == DATA_WIDTH'({ad_i, 2'b01})))
    else begin
      $error("** Error at %0t: user_dwl_o/user_dwh_o got %h/%h expected %h/%h", $time,
             dwl_i, dwh_i, DATA_WIDTH'({ad_i, 2'b00}), DATA_WIDTH'({ad_i, 2'b01}));
      fail_count++;
    end

  a_wr_beat1: assert property (@(posedge clk0) disable iff (module_rst)
    wr_prev |-> (dwl_i == DATA_WIDTH'({wr_ad_q, 2'b10}))
                && (dwh_i == DATA_WIDTH'({wr_ad_q, 2'b11})))
    else begin
      $error("** Error at %0t: user_dwl_o/user_dwh_o got %h/%h expected %h/%h", $time,
             dwl_i, dwh_i, DATA_WIDTH'({wr_ad_q, 2'b10}), DATA_WIDTH'({wr_ad_q, 2'b11}));
      fail_count++;
    end

  a_rd_addr: assert property (@(posedge clk0) disable iff (module_rst)
    !r_n_i |-> (ad_i == rd_next) && (ad_i < bursts_i))
    else begin
      $error("** Error at %0t: user_ad_o got %h expected %h", $time, ad_i, rd_next);
      fail_count++;
    end

  a_wr_hold: assert property (@(posedge clk0) disable iff (module_rst)
    wr_hold_q |-> ad_w_n_i)
    else begin
      $error("** Error at %0t: write strobe issued while write FIFO full", $time);
      fail_count++;
    end

  a_rd_hold: assert property (@(posedge clk0) disable iff (module_rst)
    rd_hold_q |-> r_n_i)
    else begin
      $error("** Error at %0t: read strobe issued while read FIFO full", $time);
      fail_count++;
    end

  a_done_count: assert property (@(posedge clk0) disable iff (module_rst)
    $rose(done_i) |-> bursts_checked_i == bursts_i)
    else begin
      $error("** Error at %0t: bursts_checked got %h expected %h", $time, bursts_checked_i,
             bursts_i);
      fail_count++;
    end

  // Gaps in the read stream also pulse data_end, only the one in the wait state counts
  a_done_on_end: assert property (@(posedge clk0) disable iff (module_rst)
    data_end_i && rd_last_q |=> done_i)
    else begin
      $error("** Error at %0t: done did not rise after end of read data", $time);
      fail_count++;
    end

  a_restart_clear: assert property (@(posedge clk0) disable iff (module_rst)
    run_start_i |=> !done_i && !fault_i && (fault_cnt_i == '0) && (bursts_checked_i == '0))
    else begin
      $error("** Error at %0t: status not cleared by a new start", $time);
      fail_count++;
    end

  a_cnt_sat: assert property (@(posedge clk0) disable iff (module_rst)
    fault_cnt_i <= FAULT_CNT_WIDTH'(FAULT_DEPTH))
    else begin
      $error("** Error at %0t: fault_cnt got %0d expected at most %0d", $time, fault_cnt_i,
             FAULT_DEPTH);
      fail_count++;
    end

endmodule

bind qdr_test_harness qdr_test_harness_assertions u_assert (
  .clk0             (clk0),
  .module_rst       (module_rst),
  .bursts_i         (mem_bursts_i),
  .wr_full_i        (user_wr_full_i),
  .rd_full_i        (user_rd_full_i),
  .ad_w_n_i         (user_ad_w_n_o),
  .d_w_n_i          (user_d_w_n_o),
  .r_n_i            (user_r_n_o),
  .ad_i             (user_ad_o),
  .dwl_i            (user_dwl_o),
  .dwh_i            (user_dwh_o),
  .run_start_i      (run_start),
  .data_end_i       (data_end),
  .done_i           (test_done),
  .fault_i          (test_fault),
  .fault_cnt_i      (fault_cnt),
  .bursts_checked_i (bursts_checked)
);

// File: read_capture.sv
// Pairs returned QDR read beats into bursts and flags the end of returned data
module read_capture
  import qdr_cfg_pkg::*;
(
  input  logic                  clk0,
  input  logic                  module_rst,
  input  logic                  user_qr_valid_i,
  input  logic [DATA_WIDTH-1:0] user_qrl_i,
  input  logic [DATA_WIDTH-1:0] user_qrh_i,
  output burst_u                burst_o,
  output logic                  burst_valid_o,
  output logic                  data_end_o
);

  logic       beat_sel;
  burst_u     burst_q;
  logic       burst_valid_q;
  logic [2:0] valid_d;
  logic       data_end_q;

  // Low cycle on valid restarts the pairing
  always_ff @(posedge clk0) begin
    if (module_rst || !user_qr_valid_i) begin
      beat_sel <= 1'b0;
    end else begin
      beat_sel <= !beat_sel;
    end
  end

  always_ff @(posedge clk0) begin
    if (user_qr_valid_i) begin
      burst_q.pair[beat_sel][BEAT_LO] <= user_qrl_i;
      burst_q.pair[beat_sel][BEAT_HI] <= user_qrh_i;
    end
  end

  always_ff @(posedge clk0) begin
    if (module_rst) begin
      burst_valid_q <= 1'b0;
      valid_d       <= '0;
      data_end_q    <= 1'b0;
    end else begin
      burst_valid_q <= user_qr_valid_i && beat_sel;
      valid_d       <= {valid_d[1:0], user_qr_valid_i};
      // Late enough for the last compare and fault write to land
      data_end_q    <= valid_d[2] && !valid_d[1];
    end
  end

  assign burst_o       = burst_q;
  assign burst_valid_o = burst_valid_q;
  assign data_end_o    = data_end_q;

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the QDR test harness simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_qdr_test_harness -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_qdr_test_harness +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "No errors"; then
  exit 0
fi
exit 1

// File: status_map_pkg.sv
// Status port address map and fault record layout, used by the status decoder
package status_map_pkg;

  import qdr_cfg_pkg::*;

  localparam int STATUS_ADDR_WIDTH = 6;

  localparam int ST_FLAGS      = 0;
  localparam int ST_BURSTS_LO  = 1;
  localparam int ST_BURSTS_HI  = 2;
  localparam int ST_FAULT_CNT  = 3;
  localparam int ST_FAULT_BASE = 4;

  // Ten words per record: address low/high, then low 16 and upper 2 bits per word
  localparam int FAULT_REC_WORDS = 10;
  localparam int REC_ADDR_LO     = 0;
  localparam int REC_ADDR_HI     = 1;
  localparam int REC_WORD_BASE   = 2;

  // Reads above this return zero
  localparam int STATUS_LAST = ST_FAULT_BASE + FAULT_DEPTH * FAULT_REC_WORDS - 1;

endpackage

// File: status_regs.sv
// Decodes the status address into one 16-bit word of flags, counts or fault records
module status_regs
  import qdr_cfg_pkg::*;
  import status_map_pkg::*;
(
  input  logic [STATUS_ADDR_WIDTH-1:0] status_addr_i,
  input  logic                         test_done_i,
  input  logic                         test_fault_i,
  input  logic [FAULT_CNT_WIDTH-1:0]   fault_cnt_i,
  input  logic [ADDR_WIDTH-1:0]        bursts_checked_i,
  input  burst_u                       rec_burst_i,
  input  logic [ADDR_WIDTH-1:0]        rec_addr_i,
  output logic [FAULT_IDX_WIDTH-1:0]   rec_sel_o,
  output logic [15:0]                  status_data_o
);

  logic [STATUS_ADDR_WIDTH-1:0] rec_off;
  logic [STATUS_ADDR_WIDTH-1:0] rec_idx;
  logic [STATUS_ADDR_WIDTH-1:0] rec_word;
  logic [STATUS_ADDR_WIDTH-1:0] word_off;
  logic [DATA_WIDTH-1:0]        rec_data;

  // Record number and word offset within it
  assign rec_off   = status_addr_i - STATUS_ADDR_WIDTH'(ST_FAULT_BASE);
  assign rec_idx   = rec_off / STATUS_ADDR_WIDTH'(FAULT_REC_WORDS);
  assign rec_word  = rec_off % STATUS_ADDR_WIDTH'(FAULT_REC_WORDS);
  assign rec_sel_o = rec_idx[FAULT_IDX_WIDTH-1:0];

  // Two status words per data word, low half first
  assign word_off = rec_word - STATUS_ADDR_WIDTH'(REC_WORD_BASE);
  assign rec_data = rec_burst_i.word[word_off[2:1]];

  always_comb begin
    status_data_o = '0;
    if (status_addr_i == STATUS_ADDR_WIDTH'(ST_FLAGS)) begin
      status_data_o = {14'b0, test_fault_i, test_done_i};
    end else if (status_addr_i == STATUS_ADDR_WIDTH'(ST_BURSTS_LO)) begin
      status_data_o = bursts_checked_i[15:0];
    end else if (status_addr_i == STATUS_ADDR_WIDTH'(ST_BURSTS_HI)) begin
      status_data_o = 16'(bursts_checked_i[ADDR_WIDTH-1:16]);
    end else if (status_addr_i == STATUS_ADDR_WIDTH'(ST_FAULT_CNT)) begin
      status_data_o = 16'(fault_cnt_i);
    end else if (status_addr_i <= STATUS_ADDR_WIDTH'(STATUS_LAST)) begin
      if (rec_word == STATUS_ADDR_WIDTH'(REC_ADDR_LO)) begin
        status_data_o = rec_addr_i[15:0];
      end else if (rec_word == STATUS_ADDR_WIDTH'(REC_ADDR_HI)) begin
        status_data_o = 16'(rec_addr_i[ADDR_WIDTH-1:16]);
      end else if (word_off[0]) begin
        status_data_o = 16'(rec_data[DATA_WIDTH-1:16]);
      end else begin
        status_data_o = rec_data[15:0];
      end
    end
  end

endmodule

// File: tb_qdr_test_harness.sv
// Testbench for the QDR test harness with a QDR memory model, fault injection and back-pressure
module tb_qdr_test_harness
  import qdr_cfg_pkg::*;
  import status_map_pkg::*;
;

  // Four runs of 16, 20, 12 and 8 bursts, each with some setup, plus margin
  localparam int TIMEOUT_CYCLES = 10 + 8 * (16 + 20 + 12 + 8) + 4 * 60 + 100;
  localparam int RD_LATENCY     = 5;

  logic                         clk0;
  logic                         module_rst;
  logic                         cal_done_i;
  logic                         start_i;
  logic [ADDR_WIDTH-1:0]        mem_bursts_i;
  logic                         user_wr_full_i  = 1'b0;
  logic                         user_rd_full_i  = 1'b0;
  logic                         user_qr_valid_i = 1'b0;
  logic [DATA_WIDTH-1:0]        user_qrl_i      = '0;
  logic [DATA_WIDTH-1:0]        user_qrh_i      = '0;
  logic [DATA_WIDTH-1:0]        user_dwl_o;
  logic [DATA_WIDTH-1:0]        user_dwh_o;
  logic [ADDR_WIDTH-1:0]        user_ad_o;
  logic                         user_ad_w_n_o;
  logic                         user_d_w_n_o;
  logic                         user_r_n_o;
  logic [STATUS_ADDR_WIDTH-1:0] status_addr_i;
  logic [15:0]                  status_data_o;

  // Memory model state
  logic [DATA_WIDTH-1:0] mem        [64][4];
  logic [DATA_WIDTH-1:0] fault_mask [64][4];
  logic [5:0]            wr_slot    = '0;
  logic                  wr_second  = 1'b0;
  logic [5:0]            rd_slot    = '0;
  logic                  rd_second  = 1'b0;
  logic [5:0]            rd_addr_q [$];
  int                    rd_due_q  [$];
  int                    mcyc       = 0;
  logic                  bp_en      = 1'b0;
  integer                seed       = 60;

  int cycles       = 0;
  int tb_errors    = 0;
  int errs_seen    = 0;
  int tests_run    = 0;
  int tests_failed = 0;

  qdr_test_harness uut (.*);

  initial begin
    clk0 = 1'b0;
    forever #50 clk0 = ~clk0;
  end

  always @(posedge clk0) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the run never reported done", cycles);
      $display("Errors found");
      $finish;
    end
  end

  // QDR model: writes land over two cycles, reads return two beats after RD_LATENCY
  always @(negedge clk0) begin
    mcyc++;
    if (!user_ad_w_n_o) begin
      mem[user_ad_o[5:0]][0] = user_dwl_o;
      mem[user_ad_o[5:0]][1] = user_dwh_o;
      wr_slot   = user_ad_o[5:0];
      wr_second = 1'b1;
    end else if (wr_second) begin
      mem[wr_slot][2] = user_dwl_o;
      mem[wr_slot][3] = user_dwh_o;
      wr_second = 1'b0;
    end
    if (!user_r_n_o) begin
      rd_addr_q.push_back(user_ad_o[5:0]);
      rd_due_q.push_back(mcyc + RD_LATENCY);
    end
    if (rd_second) begin
      user_qrl_i      = mem[rd_slot][2] ^ fault_mask[rd_slot][2];
      user_qrh_i      = mem[rd_slot][3] ^ fault_mask[rd_slot][3];
      user_qr_valid_i = 1'b1;
      rd_second       = 1'b0;
    end else if ((rd_due_q.size() > 0) && (rd_due_q[0] <= mcyc)) begin
      rd_slot         = rd_addr_q.pop_front();
      rd_due_q.delete(0);
      user_qrl_i      = mem[rd_slot][0] ^ fault_mask[rd_slot][0];
      user_qrh_i      = mem[rd_slot][1] ^ fault_mask[rd_slot][1];
      user_qr_valid_i = 1'b1;
      rd_second       = 1'b1;
    end else begin
      user_qr_valid_i = 1'b0;
    end
    user_wr_full_i = bp_en && (($random(seed) & 3) == 0);
    user_rd_full_i = bp_en && (($random(seed) & 3) == 0);
  end

  function automatic int error_total();
    return tb_errors + uut.u_assert.fail_count;
  endfunction

  task automatic clear_faults();
    for (int a = 0; a < 64; a++) begin
      for (int w = 0; w < 4; w++) begin
        fault_mask[a][w] = '0;
      end
    end
  endtask

  task automatic inject_fault(input int a);
    for (int w = 0; w < 4; w++) begin
      fault_mask[a][w] = 18'h15a5a ^ DATA_WIDTH'(a + w);
    end
  endtask

  // Status reads land in the low clock phase, away from any edge
  task automatic expect_status(input int addr, input logic [15:0] exp, input string name);
    logic [15:0] got;
    @(negedge clk0);
    status_addr_i = STATUS_ADDR_WIDTH'(addr);
    #10;
    got = status_data_o;
    assert (got == exp) else begin
      $display("** Error at %0t: status_data_o (%s) got %h expected %h", $time, name, got, exp);
      tb_errors++;
    end
  endtask

  task automatic start_run(input int bursts);
    @(negedge clk0);
    mem_bursts_i = ADDR_WIDTH'(bursts);
    start_i      = 1'b1;
    @(negedge clk0);
    start_i      = 1'b0;
  endtask

  task automatic wait_done();
    status_addr_i = STATUS_ADDR_WIDTH'(ST_FLAGS);
    @(negedge clk0);
    while (status_data_o[0] !== 1'b1) begin
      @(negedge clk0);
    end
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = error_total();
    if (errs == errs_seen) begin
      $display("Test %s: passed", name);
    end else begin
      $display("Test %s: failed with %0d errors", name, errs - errs_seen);
      tests_failed++;
    end
    tests_run++;
    errs_seen = errs;
  endtask

  task automatic check_clean_run(input int bursts);
    expect_status(ST_FLAGS, 16'h0001, "flags");
    expect_status(ST_BURSTS_LO, 16'(bursts), "bursts lo");
    expect_status(ST_BURSTS_HI, 16'h0000, "bursts hi");
    expect_status(ST_FAULT_CNT, 16'h0000, "fault count");
  endtask

  initial begin
    int                    fault_addrs [5];
    int                    a;
    int                    base;
    logic [DATA_WIDTH-1:0] word;
    int                    errs;
    fault_addrs   = '{2, 3, 5, 7, 9};
    module_rst    = 1'b1;
    cal_done_i    = 1'b1;
    start_i       = 1'b0;
    mem_bursts_i  = ADDR_WIDTH'(1);
    status_addr_i = '0;
    clear_faults();
    repeat (10) @(negedge clk0);
    module_rst = 1'b0;

    assert ({user_ad_w_n_o, user_d_w_n_o, user_r_n_o} == 3'b111) else begin
      $display("** Error at %0t: strobes got %b expected 111", $time,
               {user_ad_w_n_o, user_d_w_n_o, user_r_n_o});
      tb_errors++;
    end
    expect_status(ST_FLAGS, 16'h0000, "flags");
    finish_test("reset");

    start_run(16);
    wait_done();
    check_clean_run(16);
    finish_test("clean run");

    bp_en = 1'b1;
    start_run(20);
    wait_done();
    bp_en = 1'b0;
    check_clean_run(20);
    finish_test("back-pressure");

    for (int i = 0; i < 5; i++) begin
      inject_fault(fault_addrs[i]);
    end
    start_run(12);
    wait_done();
    expect_status(ST_FLAGS, 16'h0003, "flags");
    expect_status(ST_FAULT_CNT, 16'(FAULT_DEPTH), "fault count");
    for (int r = 0; r < FAULT_DEPTH; r++) begin
      a    = fault_addrs[r];
      base = ST_FAULT_BASE + r * FAULT_REC_WORDS;
      expect_status(base + REC_ADDR_LO, 16'(a), "record addr lo");
      expect_status(base + REC_ADDR_HI, 16'h0000, "record addr hi");
      for (int w = 0; w < 4; w++) begin
        word = DATA_WIDTH'(4 * a + w) ^ fault_mask[a][w];
        expect_status(base + REC_WORD_BASE + 2 * w, word[15:0], "record word lo");
        expect_status(base + REC_WORD_BASE + 2 * w + 1, {14'b0, word[17:16]}, "record word hi");
      end
    end
    clear_faults();
    finish_test("fault log");

    start_run(8);
    expect_status(ST_FLAGS, 16'h0000, "flags after restart");
    expect_status(ST_FAULT_CNT, 16'h0000, "fault count after restart");
    wait_done();
    check_clean_run(8);
    finish_test("restart");

    repeat (4) @(negedge clk0);
    errs = error_total();
    $display("Summary: %0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
             errs);
    if (errs == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: test_sequencer.sv
// Run sequencer that writes a counting pattern to the QDR user port and then reads it back
module test_sequencer
  import qdr_cfg_pkg::*;
(
  input  logic                  clk0,
  input  logic                  module_rst,
  input  logic                  cal_done_i,
  input  logic                  start_i,
  input  logic [ADDR_WIDTH-1:0] mem_bursts_i,
  input  logic                  user_wr_full_i,
  input  logic                  user_rd_full_i,
  input  logic                  data_end_i,
  output logic                  user_ad_w_n_o,
  output logic                  user_d_w_n_o,
  output logic                  user_r_n_o,
  output logic [ADDR_WIDTH-1:0] user_ad_o,
  output logic [DATA_WIDTH-1:0] user_dwl_o,
  output logic [DATA_WIDTH-1:0] user_dwh_o,
  output logic                  run_start_o,
  output logic                  test_done_o
);

  logic                       seq_rst;
  logic                       start_q;
  logic                       start_edge;
  logic [SEQ_STATE_WIDTH-1:0] state;
  logic [ADDR_WIDTH-1:0]      mem_addr;
  logic                       last_burst;
  logic [DATA_WIDTH-1:0]      dwl_q;
  logic [DATA_WIDTH-1:0]      dwh_q;
  logic                       done_q;

  // Lost calibration holds the run in reset
  assign seq_rst = module_rst || !cal_done_i;

  // Held high in reset so a start level already up does not launch a run
  always_ff @(posedge clk0) begin
    if (seq_rst) begin
      start_q <= 1'b1;
    end else begin
      start_q <= start_i;
    end
  end

  assign start_edge  = start_i && !start_q;
  assign run_start_o = start_edge && (state == SEQ_IDLE);
  assign last_burst  = (mem_addr == mem_bursts_i - ADDR_WIDTH'(1));

  always_ff @(posedge clk0) begin
    if (seq_rst) begin
      state <= SEQ_IDLE;
    end else begin
      case (state)
        SEQ_IDLE:  if (run_start_o) state <= SEQ_WR0;
        SEQ_WR0:   state <= SEQ_WR1;
        SEQ_WR1: begin
          if (last_burst) begin
            state <= SEQ_TURN;
          end else if (user_wr_full_i) begin
            state <= SEQ_WR_BO;
          end else begin
            state <= SEQ_WR0;
          end
        end
        SEQ_WR_BO: if (!user_wr_full_i) state <= SEQ_WR0;
        SEQ_TURN:  state <= SEQ_RD0;
        SEQ_RD0:   state <= SEQ_RD1;
        SEQ_RD1: begin
          if (last_burst) begin
            state <= SEQ_WAIT;
          end else if (user_rd_full_i) begin
            state <= SEQ_RD_BO;
          end else begin
            state <= SEQ_RD0;
          end
        end
        SEQ_RD_BO: if (!user_rd_full_i) state <= SEQ_RD0;
        SEQ_WAIT:  if (data_end_i) state <= SEQ_IDLE;
        default:   state <= SEQ_IDLE;
      endcase
    end
  end

  // One address counter, shared by both phases
  always_ff @(posedge clk0) begin
    if (seq_rst || (state == SEQ_IDLE) || (state == SEQ_TURN)) begin
      mem_addr <= '0;
    end else if ((state == SEQ_WR1) || (state == SEQ_RD1)) begin
      mem_addr <= mem_addr + ADDR_WIDTH'(1);
    end
  end

  // Write data steps by two words per beat, frozen during back-off
  always_ff @(posedge clk0) begin
    if (seq_rst || (state == SEQ_IDLE)) begin
      dwl_q <= DATA_WIDTH'(0);
      dwh_q <= DATA_WIDTH'(1);
    end else if ((state == SEQ_WR0) || (state == SEQ_WR1)) begin
      dwl_q <= dwl_q + DATA_WIDTH'(2);
      dwh_q <= dwh_q + DATA_WIDTH'(2);
    end
  end

  always_ff @(posedge clk0) begin
    if (seq_rst || run_start_o) begin
      done_q <= 1'b0;
    end else if ((state == SEQ_WAIT) && data_end_i) begin
      done_q <= 1'b1;
    end
  end

  assign user_ad_w_n_o = (state != SEQ_WR0);
  assign user_d_w_n_o  = (state != SEQ_WR0);
  assign user_r_n_o    = (state != SEQ_RD1);
  assign user_ad_o     = mem_addr;
  assign user_dwl_o    = dwl_q;
  assign user_dwh_o    = dwh_q;
  assign test_done_o   = done_q;

endmodule
